// ==== rtl/proxy_reg_pkg.sv ====
package proxy_reg_pkg;

    // --------------------
    // Register bus
    // --------------------
    localparam int REG_ADDR_WID = 12;
    localparam int REG_DATA_WID = 32;

    // Region in the upper nibble, word offset below it
    localparam int REGION_MSB = 11;
    localparam int REGION_LSB = 8;
    localparam int OFFSET_MSB = 7;
    localparam int OFFSET_LSB = 2;

    // Cycles from request pulse to ack
    localparam int REG_ACK_LATENCY = 3;

    typedef struct packed {
        logic                    wr;
        logic                    rd;
        logic [REG_ADDR_WID-1:0] addr;
        logic [REG_DATA_WID-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                    ack;
        logic                    error;
        logic [REG_DATA_WID-1:0] rdata;
    } reg_rsp_t;

    // --------------------
    // Address map
    // --------------------
    typedef enum logic [REGION_MSB-REGION_LSB:0] {
        REGION_INDIRECT = 4'd0,
        REGION_MEM      = 4'd1
    } region_e;

    typedef enum logic [OFFSET_MSB-OFFSET_LSB:0] {
        IND_TRIGGER = 6'd0,
        IND_STATUS  = 6'd1,
        IND_PRE_ID  = 6'd2,
        IND_POST_ID = 6'd3
    } ind_reg_e;

    typedef enum logic [OFFSET_MSB-OFFSET_LSB:0] {
        MEM_ADDR   = 6'd0,
        MEM_WDATA  = 6'd1,
        MEM_CMD    = 6'd2,
        MEM_RDATA  = 6'd3,
        MEM_STATUS = 6'd4
    } mem_reg_e;

    // Low bits of a MEM_CMD write
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } mem_cmd_e;

    // --------------------
    // Memory and identifiers
    // --------------------
    localparam int MEM_DEPTH    = 1024;
    localparam int MEM_ADDR_WID = $clog2(MEM_DEPTH);
    localparam int MEM_DATA_WID = 32;

    // " PRE" and "POST" in ASCII
    localparam logic [REG_DATA_WID-1:0] PRE_ID_WORD  = 32'h2050_5245;
    localparam logic [REG_DATA_WID-1:0] POST_ID_WORD = 32'h504F_5354;

endpackage : proxy_reg_pkg

// ==== rtl/proxy_stream_pkg.sv ====
package proxy_stream_pkg;

    // --------------------
    // Stream ports
    // --------------------
    localparam int STREAM_DATA_WID = 64;
    localparam int STREAM_KEEP_WID = STREAM_DATA_WID / 8;

    // Number of pass-through ports
    localparam int NUM_PORTS = 2;

    // One beat, byte enables per data byte
    typedef struct packed {
        logic [STREAM_DATA_WID-1:0] data;
        logic [STREAM_KEEP_WID-1:0] keep;
        logic                       last;
    } stream_beat_t;

endpackage : proxy_stream_pkg

// ==== rtl/proxy_ram_sp.sv ====
`timescale 1ns/100ps

module proxy_ram_sp import proxy_reg_pkg::*; (
    input  logic                    clk,
    input  logic                    i_en,
    input  logic                    i_we,
    input  logic [MEM_ADDR_WID-1:0] i_addr,
    input  logic [MEM_DATA_WID-1:0] i_wdata,
    output logic [MEM_DATA_WID-1:0] o_rdata
);
    logic [MEM_DATA_WID-1:0] mem [MEM_DEPTH];
    logic [MEM_DATA_WID-1:0] rdata_q;

    // Single port, read or write per cycle
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                rdata_q <= mem[i_addr];
            end
        end
    end

    assign o_rdata = rdata_q;

endmodule : proxy_ram_sp

// ==== rtl/proxy_stream_pipe.sv ====
`timescale 1ns/100ps

module proxy_stream_pipe import proxy_stream_pkg::*; (
    input  logic         clk,
    input  logic         srst,
    input  stream_beat_t i_in_beat,
    input  logic         i_in_valid,
    output logic         o_in_ready,
    output stream_beat_t o_out_beat,
    output logic         o_out_valid,
    input  logic         i_out_ready
);
    stream_beat_t out_beat_q;
    stream_beat_t skid_beat_q;
    logic         out_valid_q;
    logic         skid_valid_q;
    logic         in_fire;
    logic         out_load;

    assign o_in_ready = !skid_valid_q;
    assign in_fire    = i_in_valid && o_in_ready;
    // Output register empty or draining this cycle
    assign out_load   = !out_valid_q || i_out_ready;

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_beat_q <= skid_valid_q ? skid_beat_q : i_in_beat;
        end else if (in_fire) begin
            skid_beat_q <= i_in_beat;
        end
        if (srst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_load) begin
            out_valid_q  <= skid_valid_q || in_fire;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    assign o_out_beat  = out_beat_q;
    assign o_out_valid = out_valid_q;

    a_hold_on_stall : assert property (@(posedge clk) disable iff (srst)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_beat));

endmodule : proxy_stream_pipe

// ==== rtl/proxy_reg_decoder.sv ====
`timescale 1ns/100ps

module proxy_reg_decoder import proxy_reg_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  reg_req_t i_req,
    output reg_rsp_t o_rsp,
    output reg_req_t o_ind_req,
    input  reg_rsp_t i_ind_rsp,
    output reg_req_t o_mem_req,
    input  reg_rsp_t i_mem_rsp
);
    region_e                 region;
    logic                    req_any;
    logic                    hit_ind;
    logic                    hit_mem;
    logic [REG_ADDR_WID-1:0] addr_q;
    logic [REG_DATA_WID-1:0] wdata_q;
    logic                    ind_wr_q;
    logic                    ind_rd_q;
    logic                    mem_wr_q;
    logic                    mem_rd_q;
    logic                    unmapped_q;
    logic                    unmapped_d;
    logic                    pending;
    reg_rsp_t                rsp_q;

    assign region  = region_e'(i_req.addr[REGION_MSB:REGION_LSB]);
    assign req_any = i_req.wr || i_req.rd;
    assign hit_ind = region == REGION_INDIRECT;
    assign hit_mem = region == REGION_MEM;

    // --------------------
    // Request stage
    // --------------------
    always_ff @(posedge clk) begin
        addr_q  <= i_req.addr;
        wdata_q <= i_req.wdata;
        if (srst) begin
            ind_wr_q   <= 1'b0;
            ind_rd_q   <= 1'b0;
            mem_wr_q   <= 1'b0;
            mem_rd_q   <= 1'b0;
            unmapped_q <= 1'b0;
            unmapped_d <= 1'b0;
        end else begin
            ind_wr_q   <= i_req.wr && hit_ind;
            ind_rd_q   <= i_req.rd && hit_ind;
            mem_wr_q   <= i_req.wr && hit_mem;
            mem_rd_q   <= i_req.rd && hit_mem;
            unmapped_q <= req_any && !hit_ind && !hit_mem;
            // Stand-in for the target cycle
            unmapped_d <= unmapped_q;
        end
    end

    assign o_ind_req = '{wr: ind_wr_q, rd: ind_rd_q, addr: addr_q, wdata: wdata_q};
    assign o_mem_req = '{wr: mem_wr_q, rd: mem_rd_q, addr: addr_q, wdata: wdata_q};

    // --------------------
    // Response stage
    // --------------------
    always_ff @(posedge clk) begin
        rsp_q.error <= (i_ind_rsp.ack && i_ind_rsp.error) ||
                       (i_mem_rsp.ack && i_mem_rsp.error) || unmapped_d;
        rsp_q.rdata <= ({REG_DATA_WID{i_ind_rsp.ack}} & i_ind_rsp.rdata) |
                       ({REG_DATA_WID{i_mem_rsp.ack}} & i_mem_rsp.rdata);
        if (srst) begin
            rsp_q.ack <= 1'b0;
        end else begin
            rsp_q.ack <= i_ind_rsp.ack || i_mem_rsp.ack || unmapped_d;
        end
    end

    assign o_rsp = rsp_q;

    // Access in flight, request until ack
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (req_any) begin
            pending <= 1'b1;
        end else if (rsp_q.ack) begin
            pending <= 1'b0;
        end
    end

    a_single_strobe : assert property (@(posedge clk) disable iff (srst)
        !(i_req.wr && i_req.rd));
    a_no_overlap : assert property (@(posedge clk) disable iff (srst)
        req_any |-> (!pending || rsp_q.ack));
    a_ack_latency : assert property (@(posedge clk) disable iff (srst)
        req_any |-> ##REG_ACK_LATENCY rsp_q.ack);

endmodule : proxy_reg_decoder

// ==== rtl/proxy_indirect_regs.sv ====
`timescale 1ns/100ps

module proxy_indirect_regs import proxy_reg_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  reg_req_t i_req,
    output reg_rsp_t o_rsp
);
    ind_reg_e                offset;
    logic                    trigger_wr;
    logic                    trigger_wr_q;
    logic [REG_DATA_WID-1:0] trigger_q;
    logic [REG_DATA_WID-1:0] status_q;
    logic [REG_DATA_WID-1:0] rd_data;
    logic                    access_err;
    reg_rsp_t                rsp_q;

    assign offset     = ind_reg_e'(i_req.addr[OFFSET_MSB:OFFSET_LSB]);
    assign trigger_wr = i_req.wr && (offset == IND_TRIGGER);

    // --------------------
    // Trigger and status
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            trigger_q    <= '0;
            trigger_wr_q <= 1'b0;
            status_q     <= '0;
        end else begin
            trigger_wr_q <= trigger_wr;
            if (trigger_wr) begin
                trigger_q <= i_req.wdata;
            end
            // Status follows one cycle behind the trigger write
            if (trigger_wr_q) begin
                status_q <= trigger_q;
            end
        end
    end

    // --------------------
    // Read mux and error check
    // --------------------
    always_comb begin
        rd_data    = '0;
        access_err = 1'b0;
        case (offset)
            IND_TRIGGER: rd_data = trigger_q;
            IND_STATUS: begin
                rd_data    = status_q;
                access_err = i_req.wr;
            end
            IND_PRE_ID: begin
                rd_data    = PRE_ID_WORD;
                access_err = i_req.wr;
            end
            IND_POST_ID: begin
                rd_data    = POST_ID_WORD;
                access_err = i_req.wr;
            end
            default: access_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        rsp_q.error <= access_err;
        rsp_q.rdata <= i_req.rd ? rd_data : '0;
        if (srst) begin
            rsp_q.ack <= 1'b0;
        end else begin
            rsp_q.ack <= i_req.wr || i_req.rd;
        end
    end

    assign o_rsp = rsp_q;

    a_ack_single : assert property (@(posedge clk) disable iff (srst)
        rsp_q.ack |=> !rsp_q.ack);

endmodule : proxy_indirect_regs

// ==== rtl/proxy_mem_ctrl.sv ====
`timescale 1ns/100ps

module proxy_mem_ctrl import proxy_reg_pkg::*; (
    input  logic                    clk,
    input  logic                    srst,
    input  reg_req_t                i_req,
    output reg_rsp_t                o_rsp,
    output logic                    o_ram_en,
    output logic                    o_ram_we,
    output logic [MEM_ADDR_WID-1:0] o_ram_addr,
    output logic [MEM_DATA_WID-1:0] o_ram_wdata,
    input  logic [MEM_DATA_WID-1:0] i_ram_rdata
);
    typedef enum logic [2:0] {
        ST_FILL,
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_CAPTURE
    } state_e;

    state_e                  state;
    state_e                  state_nxt;
    mem_reg_e                offset;
    mem_cmd_e                cmd;
    logic                    cmd_wr;
    logic                    fill_done;
    logic                    busy;
    logic [MEM_ADDR_WID-1:0] fill_addr;
    logic [MEM_ADDR_WID-1:0] addr_q;
    logic [MEM_DATA_WID-1:0] wdata_q;
    logic [MEM_DATA_WID-1:0] rdata_q;
    logic [REG_DATA_WID-1:0] rd_data;
    logic                    access_err;
    reg_rsp_t                rsp_q;

    assign offset    = mem_reg_e'(i_req.addr[OFFSET_MSB:OFFSET_LSB]);
    assign cmd       = mem_cmd_e'(i_req.wdata[1:0]);
    assign cmd_wr    = i_req.wr && (offset == MEM_CMD);
    assign fill_done = state != ST_FILL;
    assign busy      = state inside {ST_WRITE, ST_READ, ST_CAPTURE};

    // --------------------
    // Command FSM
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_FILL: begin
                if (fill_addr == MEM_ADDR_WID'(MEM_DEPTH - 1)) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (cmd_wr && cmd == CMD_READ) begin
                    state_nxt = ST_READ;
                end else if (cmd_wr && cmd == CMD_WRITE) begin
                    state_nxt = ST_WRITE;
                end
            end
            ST_READ:  state_nxt = ST_CAPTURE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= ST_FILL;
            fill_addr <= '0;
            addr_q    <= '0;
            wdata_q   <= '0;
            rdata_q   <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_FILL) begin
                fill_addr <= fill_addr + 1'b1;
            end
            if (i_req.wr && offset == MEM_ADDR) begin
                addr_q <= i_req.wdata[MEM_ADDR_WID-1:0];
            end
            if (i_req.wr && offset == MEM_WDATA) begin
                wdata_q <= i_req.wdata;
            end
            // RAM word arrives one cycle after ST_READ
            if (state == ST_CAPTURE) begin
                rdata_q <= i_ram_rdata;
            end
        end
    end

    // RAM port, zero fill after reset
    assign o_ram_en    = state inside {ST_FILL, ST_WRITE, ST_READ};
    assign o_ram_we    = state inside {ST_FILL, ST_WRITE};
    assign o_ram_addr  = fill_done ? addr_q : fill_addr;
    assign o_ram_wdata = fill_done ? wdata_q : '0;

    // --------------------
    // Register response
    // --------------------
    always_comb begin
        rd_data    = '0;
        access_err = 1'b0;
        case (offset)
            MEM_ADDR:  rd_data = REG_DATA_WID'(addr_q);
            MEM_WDATA: rd_data = wdata_q;
            // Refused while the fill runs
            MEM_CMD:   access_err = i_req.wr && !fill_done;
            MEM_RDATA: begin
                rd_data    = rdata_q;
                access_err = i_req.wr;
            end
            MEM_STATUS: begin
                rd_data    = REG_DATA_WID'({busy, fill_done});
                access_err = i_req.wr;
            end
            default: access_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        rsp_q.error <= access_err;
        rsp_q.rdata <= i_req.rd ? rd_data : '0;
        if (srst) begin
            rsp_q.ack <= 1'b0;
        end else begin
            rsp_q.ack <= i_req.wr || i_req.rd;
        end
    end

    assign o_rsp = rsp_q;

    // Host writes reach the RAM only right after a command write
    a_ram_we_src : assert property (@(posedge clk) disable iff (srst)
        o_ram_we |-> (state == ST_FILL) || (state == ST_WRITE && $past(cmd_wr)));

endmodule : proxy_mem_ctrl

// ==== rtl/proxy_test.sv ====
`timescale 1ns/100ps

module proxy_test import proxy_reg_pkg::*, proxy_stream_pkg::*; (
    input  logic         clk,
    input  logic         srst,
    input  reg_req_t     i_req,
    output reg_rsp_t     o_rsp,
    input  stream_beat_t i_in_beat   [NUM_PORTS],
    input  logic         i_in_valid  [NUM_PORTS],
    output logic         o_in_ready  [NUM_PORTS],
    output stream_beat_t o_out_beat  [NUM_PORTS],
    output logic         o_out_valid [NUM_PORTS],
    input  logic         i_out_ready [NUM_PORTS]
);
    reg_req_t                ind_req;
    reg_rsp_t                ind_rsp;
    reg_req_t                mem_req;
    reg_rsp_t                mem_rsp;
    logic                    ram_en;
    logic                    ram_we;
    logic [MEM_ADDR_WID-1:0] ram_addr;
    logic [MEM_DATA_WID-1:0] ram_wdata;
    logic [MEM_DATA_WID-1:0] ram_rdata;

    // --------------------
    // Register path
    // --------------------
    proxy_reg_decoder u_decoder (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_req     ( i_req ),
        .o_rsp     ( o_rsp ),
        .o_ind_req ( ind_req ),
        .i_ind_rsp ( ind_rsp ),
        .o_mem_req ( mem_req ),
        .i_mem_rsp ( mem_rsp )
    );

    proxy_indirect_regs u_indirect_regs (
        .clk   ( clk ),
        .srst  ( srst ),
        .i_req ( ind_req ),
        .o_rsp ( ind_rsp )
    );

    proxy_mem_ctrl u_mem_ctrl (
        .clk         ( clk ),
        .srst        ( srst ),
        .i_req       ( mem_req ),
        .o_rsp       ( mem_rsp ),
        .o_ram_en    ( ram_en ),
        .o_ram_we    ( ram_we ),
        .o_ram_addr  ( ram_addr ),
        .o_ram_wdata ( ram_wdata ),
        .i_ram_rdata ( ram_rdata )
    );

    proxy_ram_sp u_ram (
        .clk     ( clk ),
        .i_en    ( ram_en ),
        .i_we    ( ram_we ),
        .i_addr  ( ram_addr ),
        .i_wdata ( ram_wdata ),
        .o_rdata ( ram_rdata )
    );

    // --------------------
    // Stream pass-through
    // --------------------
    for (genvar g_port = 0; g_port < NUM_PORTS; g_port++) begin : g_port_pipe
        proxy_stream_pipe u_pipe (
            .clk         ( clk ),
            .srst        ( srst ),
            .i_in_beat   ( i_in_beat[g_port] ),
            .i_in_valid  ( i_in_valid[g_port] ),
            .o_in_ready  ( o_in_ready[g_port] ),
            .o_out_beat  ( o_out_beat[g_port] ),
            .o_out_valid ( o_out_valid[g_port] ),
            .i_out_ready ( i_out_ready[g_port] )
        );
    end : g_port_pipe

endmodule : proxy_test

// ==== verification/proxy_test_tb.sv ====
`timescale 1ns/100ps

module proxy_test_tb import proxy_reg_pkg::*, proxy_stream_pkg::*; ();

    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 16;
    localparam int ACK_WAIT         = REG_ACK_LATENCY + 4;
    localparam int NUM_MEM_WORDS    = 8;
    localparam int NUM_ZERO_READS   = 4;
    localparam int BEATS_PER_PORT   = 200;
    localparam int NUM_REG_ACCESSES = 100;
    localparam int WATCHDOG_CYCLES  = MEM_DEPTH + 200 * NUM_REG_ACCESSES
                                      + 40 * BEATS_PER_PORT;

    logic         clk = 1'b0;
    logic         srst;
    reg_req_t     req;
    reg_rsp_t     rsp;
    stream_beat_t in_beat   [NUM_PORTS];
    logic         in_valid  [NUM_PORTS];
    logic         in_ready  [NUM_PORTS];
    stream_beat_t out_beat  [NUM_PORTS];
    logic         out_valid [NUM_PORTS];
    logic         out_ready [NUM_PORTS];

    logic [31:0]  lfsr_state = 32'd48;
    int           mismatch_count = 0;
    int           fail_count = 0;
    logic [31:0]  model [MEM_DEPTH];
    stream_beat_t exp_q [$];

    always #(CLK_PERIOD / 2) clk = !clk;

    proxy_test dut (
        .clk         ( clk ),
        .srst        ( srst ),
        .i_req       ( req ),
        .o_rsp       ( rsp ),
        .i_in_beat   ( in_beat ),
        .i_in_valid  ( in_valid ),
        .o_in_ready  ( in_ready ),
        .o_out_beat  ( out_beat ),
        .o_out_valid ( out_valid ),
        .i_out_ready ( out_ready )
    );

    // --------------------
    // Concurrent checks
    // --------------------
    a_ack_timing : assert property (@(posedge clk) disable iff (srst)
        rsp.ack |-> $past(req.wr || req.rd, REG_ACK_LATENCY))
        else begin
            fail_count++;
            $display("Acknowledge at %0t has no request %0d cycles before it",
                     $time, REG_ACK_LATENCY);
        end

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_hold_check
        a_out_hold : assert property (@(posedge clk) disable iff (srst)
            out_valid[g] && !out_ready[g] |=> out_valid[g] && $stable(out_beat[g]))
            else begin
                mismatch_count++;
                $display("MISMATCH at %0t: port %0d output changed while stalled", $time, g);
            end
    end : g_hold_check

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [REG_ADDR_WID-1:0] ind_reg_addr(input logic [5:0] off);
        return {REGION_INDIRECT, off, 2'b00};
    endfunction

    function automatic logic [REG_ADDR_WID-1:0] mem_reg_addr(input logic [5:0] off);
        return {REGION_MEM, off, 2'b00};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic reg_access(input logic wr, input logic [REG_ADDR_WID-1:0] addr,
                              input logic [REG_DATA_WID-1:0] wdata, output reg_rsp_t r);
        int cycles;
        cycles = 0;
        req = '{wr: wr, rd: !wr, addr: addr, wdata: wdata};
        do begin
            @(posedge clk);
            #1;
            req = '0;
            cycles++;
        end while (!rsp.ack && cycles < ACK_WAIT);
        r = rsp;
        if (!rsp.ack) begin
            fail_count++;
            $display("No acknowledge for access to address %0h at %0t", addr, $time);
        end else begin
            check_value("ack latency", 32'(cycles), 32'(REG_ACK_LATENCY));
        end
    endtask

    task automatic write_check(input logic [REG_ADDR_WID-1:0] addr, input logic [31:0] data,
                               input logic exp_err, input string what);
        reg_rsp_t r;
        reg_access(1'b1, addr, data, r);
        check_value({what, " error"}, 32'(r.error), 32'(exp_err));
    endtask

    task automatic read_check(input logic [REG_ADDR_WID-1:0] addr, input logic [31:0] exp,
                              input logic exp_err, input string what);
        reg_rsp_t r;
        reg_access(1'b0, addr, '0, r);
        check_value({what, " error"}, 32'(r.error), 32'(exp_err));
        check_value({what, " data"}, r.rdata, exp);
    endtask

    // --------------------
    // Memory proxy
    // --------------------
    task automatic wait_fill();
        reg_rsp_t r;
        int polls;
        polls = 0;
        do begin
            reg_access(1'b0, mem_reg_addr(MEM_STATUS), '0, r);
            check_value("status busy", 32'(r.rdata[1]), 32'd0);
            polls++;
        end while (!r.rdata[0] && polls < MEM_DEPTH);
        if (!r.rdata[0]) begin
            fail_count++;
            $display("Reset fill never reported done");
        end
    endtask

    task automatic mem_write(input logic [MEM_ADDR_WID-1:0] a, input logic [31:0] d);
        write_check(mem_reg_addr(MEM_ADDR), 32'(a), 1'b0, "mem addr");
        write_check(mem_reg_addr(MEM_WDATA), d, 1'b0, "mem wdata");
        write_check(mem_reg_addr(MEM_CMD), 32'(CMD_WRITE), 1'b0, "write cmd");
        model[a] = d;
    endtask

    task automatic mem_read_check(input logic [MEM_ADDR_WID-1:0] a);
        write_check(mem_reg_addr(MEM_ADDR), 32'(a), 1'b0, "mem addr");
        write_check(mem_reg_addr(MEM_CMD), 32'(CMD_READ), 1'b0, "read cmd");
        // Poll right behind the command, fill done and never busy
        read_check(mem_reg_addr(MEM_STATUS), 32'd1, 1'b0, "status after read cmd");
        read_check(mem_reg_addr(MEM_RDATA), model[a], 1'b0, "mem rdata");
    endtask

    // --------------------
    // Streams
    // --------------------
    task automatic drive_port(input int p);
        stream_beat_t beat;
        int sent;
        logic accepted;
        sent = 0;
        while (sent < BEATS_PER_PORT) begin
            if (!in_valid[p] && rand_bits(1) == 64'd1) begin
                beat.data   = rand_bits(STREAM_DATA_WID);
                beat.keep   = STREAM_KEEP_WID'(rand_bits(STREAM_KEEP_WID));
                beat.last   = 1'(rand_bits(1));
                in_beat[p]  = beat;
                in_valid[p] = 1'b1;
            end
            // Accepted at the coming edge
            accepted = in_valid[p] && in_ready[p];
            if (accepted) begin
                exp_q.push_back(in_beat[p]);
                sent++;
            end
            @(posedge clk);
            #1;
            if (accepted) begin
                in_valid[p] = 1'b0;
            end
        end
    endtask

    task automatic watch_port(input int p);
        stream_beat_t exp;
        int got;
        got = 0;
        while (got < BEATS_PER_PORT) begin
            out_ready[p] = 1'(rand_bits(1));
            if (out_valid[p] && out_ready[p]) begin
                if (exp_q.size() == 0) begin
                    fail_count++;
                    $display("Port %0d produced a beat that was never sent at %0t", p, $time);
                end else begin
                    exp = exp_q.pop_front();
                    assert (out_beat[p] == exp) else begin
                        mismatch_count++;
                        $display("MISMATCH at %0t: port %0d beat got %h expected %h",
                                 $time, p, out_beat[p], exp);
                    end
                end
                got++;
            end
            @(posedge clk);
            #1;
        end
        out_ready[p] = 1'b0;
    endtask

    task automatic run_port(input int p);
        exp_q.delete();
        fork
            drive_port(p);
            watch_port(p);
        join
        if (exp_q.size() != 0) begin
            fail_count++;
            $display("Port %0d lost %0d beats", p, exp_q.size());
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic [31:0]             trig;
        logic [MEM_ADDR_WID-1:0] addrs [NUM_MEM_WORDS];
        req  = '0;
        srst = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p]   = '0;
            in_valid[p]  = 1'b0;
            out_ready[p] = 1'b0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        srst = 1'b0;

        // Fill still running
        read_check(mem_reg_addr(MEM_STATUS), 32'd0, 1'b0, "status during fill");
        write_check(mem_reg_addr(MEM_CMD), 32'(CMD_WRITE), 1'b1, "cmd during fill");

        read_check(ind_reg_addr(IND_PRE_ID), PRE_ID_WORD, 1'b0, "pre id");
        read_check(ind_reg_addr(IND_POST_ID), POST_ID_WORD, 1'b0, "post id");

        trig = 32'(rand_bits(32));
        write_check(ind_reg_addr(IND_TRIGGER), trig, 1'b0, "trigger");
        read_check(ind_reg_addr(IND_TRIGGER), trig, 1'b0, "trigger readback");
        read_check(ind_reg_addr(IND_STATUS), trig, 1'b0, "status");
        write_check(ind_reg_addr(IND_STATUS), ~trig, 1'b1, "status write");
        read_check(ind_reg_addr(IND_STATUS), trig, 1'b0, "status kept");

        // Region 5 is unmapped
        read_check({4'd5, 6'd0, 2'b00}, 32'd0, 1'b1, "unmapped read");
        write_check({4'd5, 6'd1, 2'b00}, trig, 1'b1, "unmapped write");

        wait_fill();
        for (int i = 0; i < NUM_ZERO_READS; i++) begin
            mem_read_check(MEM_ADDR_WID'(rand_bits(MEM_ADDR_WID)));
        end

        for (int i = 0; i < NUM_MEM_WORDS; i++) begin
            addrs[i] = MEM_ADDR_WID'(rand_bits(MEM_ADDR_WID));
            mem_write(addrs[i], 32'(rand_bits(32)));
        end
        // Read back newest first
        for (int i = NUM_MEM_WORDS - 1; i >= 0; i--) begin
            mem_read_check(addrs[i]);
        end

        for (int p = 0; p < NUM_PORTS; p++) begin
            run_port(p);
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule : proxy_test_tb

// ==== proxy_test.f ====
rtl/proxy_reg_pkg.sv
rtl/proxy_stream_pkg.sv
rtl/proxy_ram_sp.sv
rtl/proxy_stream_pipe.sv
rtl/proxy_reg_decoder.sv
rtl/proxy_indirect_regs.sv
rtl/proxy_mem_ctrl.sv
rtl/proxy_test.sv
verification/proxy_test_tb.sv

// ==== Makefile ====
# Verilator build and run for the proxy test block

BIN  := obj_dir/Vproxy_test_tb
SRCS := $(shell cat proxy_test.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): proxy_test.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module proxy_test_tb -f proxy_test.f

# The log decides pass or fail
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
